// File: Makefile
TOP = issue_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: dv/issue_assertions.sv
module issue_assertions
	import issue_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic flush,
	input wb_bus_t wb
);
	timeunit 1ns;
	timeprecision 1ps;

	// ============================================================
	// Four-phase link
	// ============================================================

	// Ack only ever rises in answer to a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		(!ack && !req) |=> !ack)
		else $error("ack rose while req was low");

	// Ack holds for as long as the source keeps req high
	ack_holds: assert property (@(posedge clk) disable iff (rst)
		(ack && req) |=> ack)
		else $error("ack fell before req was seen low");

	// Once req is seen low, ack drops on the next edge
	ack_release: assert property (@(posedge clk) disable iff (rst)
		(ack && !req) |=> !ack)
		else $error("ack stayed high after req went low");

	// ============================================================
	// Flush
	// ============================================================

	// Everything in flight is killed, so the next cycle carries no writeback
	flush_kills_wb: assert property (@(posedge clk) disable iff (rst)
		flush |=> !wb.v)
		else $error("writeback seen on the cycle after a flush");

endmodule

bind issue_top issue_assertions u_assertions (
	.clk(clk),
	.rst(rst),
	.req(req),
	.ack(ack),
	.flush(flush),
	.wb(wb)
);

// File: dv/issue_tb.sv
module issue_tb
	import issue_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// Each instruction needs the handshake, a possible stall and a req delay
	localparam int NUM_DIRECTED = 21;
	localparam int NUM_RANDOM = 200;
	localparam int WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 20 + 500;

	// Expected writeback plus the cycle on which its ack was seen
	typedef struct packed {
		logic [REG_W-1:0] rd;
		logic [DATA_W-1:0] data;
		logic [31:0] cyc;
	} exp_wb_t;

	logic clk;
	logic rst;
	logic req;
	logic ack;
	instr_t instr;
	logic flush;
	logic [REG_W-1:0] host_addr;
	logic [DATA_W-1:0] host_data;
	wb_bus_t wb;

	// Reference register state in program order where r0 stays zero
	logic [DATA_W-1:0] model [NUM_REGS];
	exp_wb_t exp_q [$];
	int cycle = 0;
	logic [31:0] seed;

	issue_top uut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.instr(instr),
		.flush(flush),
		.host_addr(host_addr),
		.host_data(host_data),
		.wb(wb)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Cycle count that is read only at the falling edge
	always @(posedge clk)
		cycle <= cycle + 1;

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_on_error($sformatf("Timeout: the run did not finish in %0d cycles",
			WATCHDOG_CYCLES));
	end

	// ============================================================
	// Reporting and helpers
	// ============================================================

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp)
		else
			stop_on_error($sformatf("ERR %0t %s expected 0x%h actual 0x%h",
				$time, name, exp, act));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic instr_t make_instr(input opcode_e op, input logic [REG_W-1:0] rd,
		input logic [REG_W-1:0] ra, input logic [REG_W-1:0] rb, input logic [DATA_W-1:0] imm);
		instr_t ins;
		ins.opcode = op;
		ins.rd = rd;
		ins.ra = ra;
		ins.rb = rb;
		ins.imm = imm;
		return ins;
	endfunction

	// NOP and the spare encodings produce no writeback
	function automatic bit writes_reg(input opcode_e op);
		return op inside {OP_LI, OP_ADD, OP_SUB, OP_MUL, OP_AND};
	endfunction

	// Wrapping 16-bit arithmetic on the committed model values
	function automatic logic [DATA_W-1:0] predict_result(input instr_t ins);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] res;
		a = model[ins.ra];
		b = model[ins.rb];
		case (ins.opcode)
			OP_LI: res = ins.imm;
			OP_ADD: res = a + b;
			OP_SUB: res = a - b;
			OP_MUL: res = a * b;
			OP_AND: res = a & b;
			default: res = '0;
		endcase
		return res;
	endfunction

	// ============================================================
	// Source side of the req/ack link
	// ============================================================

	// Full four-phase transfer. A nonzero kill_stage flushes the op as it leaves that stage
	task automatic send_instr(input instr_t ins, input int delay, input int kill_stage,
		output int ack_cyc);
		exp_wb_t e;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		instr <= ins;
		req <= 1'b1;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		ack_cyc = cycle;
		// Killed ops leave no trace in the model
		if (writes_reg(ins.opcode) && (kill_stage == 0))
		begin
			e.rd = ins.rd;
			e.data = predict_result(ins);
			e.cyc = ack_cyc;
			exp_q.push_back(e);
			if (ins.rd != '0)
				model[ins.rd] = e.data;
		end
		@(posedge clk);
		req <= 1'b0;
		// The op sits in stage 2 after this edge and moves one stage per edge
		if (kill_stage != 0)
		begin
			repeat (kill_stage - 2) @(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
		end
		@(negedge clk);
		while (ack)
			@(negedge clk);
	endtask

	task automatic drain_writebacks();
		@(negedge clk);
		while (exp_q.size() != 0)
			@(negedge clk);
		// The register file commits on the edge after the last writeback
		@(posedge clk);
	endtask

	task automatic host_check(input int idx);
		@(posedge clk);
		host_addr <= REG_W'(idx);
		@(negedge clk);
		check_val($sformatf("host_data[r%0d]", idx), model[idx], host_data);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < NUM_REGS; i++)
			host_check(i);
	endtask

	// Writebacks come in issue order, three cycles after their ack
	task automatic check_writeback();
		exp_wb_t e;
		assert (exp_q.size() != 0)
		else
			stop_on_error($sformatf("Writeback to r%0d at %0t with nothing outstanding",
				wb.rd, $time));
		e = exp_q.pop_front();
		check_val("wb.rd", 16'(e.rd), 16'(wb.rd));
		check_val("wb.data", e.data, wb.data);
		assert (cycle == e.cyc + 32'd3)
		else
			stop_on_error($sformatf("Writeback to r%0d came at cycle %0d, expected cycle %0d",
				wb.rd, cycle, e.cyc + 32'd3));
	endtask

	always @(negedge clk)
	begin
		if (!rst && wb.v)
			check_writeback();
	end

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic test_reset_state();
		@(negedge clk);
		check_val("ack", 16'h0000, 16'(ack));
		check_val("wb.v", 16'h0000, 16'(wb.v));
		check_all_regs();
	endtask

	task automatic test_arithmetic();
		int c;
		send_instr(make_instr(OP_LI, 4'd1, 4'd0, 4'd0, 16'h8001), 0, 0, c);
		send_instr(make_instr(OP_LI, 4'd2, 4'd0, 4'd0, 16'h7fff), 0, 0, c);
		send_instr(make_instr(OP_LI, 4'd3, 4'd0, 4'd0, 16'h0123), 0, 0, c);
		send_instr(make_instr(OP_LI, 4'd4, 4'd0, 4'd0, 16'h1234), 0, 0, c);
		// Sum and difference both wrap past 16 bits
		send_instr(make_instr(OP_ADD, 4'd5, 4'd1, 4'd2, 16'h0000), 0, 0, c);
		send_instr(make_instr(OP_SUB, 4'd6, 4'd3, 4'd4, 16'h0000), 0, 0, c);
		send_instr(make_instr(OP_MUL, 4'd7, 4'd1, 4'd3, 16'h0000), 0, 0, c);
		send_instr(make_instr(OP_AND, 4'd8, 4'd2, 4'd4, 16'h0000), 0, 0, c);
		drain_writebacks();
		check_all_regs();
	endtask

	task automatic test_raw_hazard();
		int p;
		int d;
		int d2;
		send_instr(make_instr(OP_LI, 4'd7, 4'd0, 4'd0, 16'h0005), 0, 0, p);
		send_instr(make_instr(OP_ADD, 4'd8, 4'd7, 4'd7, 16'h0000), 0, 0, d);
		// Producer commits at E+4, so the consumer cannot issue before E+5
		assert (d >= p + 5)
		else
			stop_on_error($sformatf("ADD r8 issued %0d cycles after its producer", d - p));
		send_instr(make_instr(OP_SUB, 4'd9, 4'd8, 4'd7, 16'h0000), 0, 0, d2);
		assert (d2 >= d + 5)
		else
			stop_on_error($sformatf("SUB r9 issued %0d cycles after its producer", d2 - d));
		drain_writebacks();
		host_check(8);
		host_check(9);
	endtask

	task automatic test_r0();
		int p;
		int d;
		send_instr(make_instr(OP_LI, 4'd0, 4'd0, 4'd0, 16'hbeef), 0, 0, p);
		send_instr(make_instr(OP_ADD, 4'd10, 4'd0, 4'd0, 16'h0000), 0, 0, d);
		// A stall would push the ack past the plain handshake spacing
		assert (d - p <= 4)
		else
			stop_on_error($sformatf("ADD with r0 sources stalled for %0d cycles", d - p));
		send_instr(make_instr(OP_SUB, 4'd15, 4'd3, 4'd0, 16'h0000), 0, 0, d);
		drain_writebacks();
		host_check(0);
		host_check(10);
		host_check(15);
	endtask

	task automatic test_flush();
		int c;
		send_instr(make_instr(OP_LI, 4'd11, 4'd0, 4'd0, 16'h1111), 0, 0, c);
		// A kill in stage 3 leaves the op one edge short of the writeback port
		send_instr(make_instr(OP_LI, 4'd11, 4'd0, 4'd0, 16'h2222), 0, 3, c);
		send_instr(make_instr(OP_ADD, 4'd12, 4'd11, 4'd11, 16'h0000), 0, 2, c);
		send_instr(make_instr(OP_MUL, 4'd13, 4'd11, 4'd1, 16'h0000), 0, 3, c);
		drain_writebacks();
		host_check(11);
		host_check(12);
		host_check(13);
		// These hang unless rollback returned r11 to r13 to valid
		send_instr(make_instr(OP_ADD, 4'd14, 4'd11, 4'd12, 16'h0000), 0, 0, c);
		send_instr(make_instr(OP_SUB, 4'd12, 4'd13, 4'd11, 16'h0000), 0, 0, c);
		send_instr(make_instr(OP_AND, 4'd13, 4'd11, 4'd14, 16'h0000), 0, 0, c);
		drain_writebacks();
		check_all_regs();
	endtask

	task automatic test_random_stream();
		int c;
		int delay;
		instr_t ins;
		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			seed = xorshift(seed);
			ins.opcode = opcode_e'(3'(seed % 32'd6));
			ins.rd = seed[11:8];
			ins.ra = seed[15:12];
			ins.rb = seed[19:16];
			delay = int'(seed[21:20]);
			seed = xorshift(seed);
			ins.imm = seed[23:8];
			send_instr(ins, delay, 0, c);
		end
		drain_writebacks();
		check_all_regs();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial
	begin
		rst <= 1'b1;
		req <= 1'b0;
		flush <= 1'b0;
		instr <= '0;
		host_addr <= '0;
		seed = 32'hffd;
		for (int i = 0; i < NUM_REGS; i++)
			model[i] = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		test_reset_state();
		test_arithmetic();
		test_raw_hazard();
		test_r0();
		test_flush();
		test_random_stream();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: project.f
source/issue_pkg.sv
source/instr_decoder.sv
source/reg_scoreboard.sv
source/issue_stage.sv
source/exec_pipe.sv
source/reg_file.sv
source/issue_top.sv
dv/issue_assertions.sv
dv/issue_tb.sv

// File: source/exec_pipe.sv
module exec_pipe
	import issue_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic will_issue,
	input issue_op_t issue_op,
	input logic flush,
	output wb_bus_t wb,
	output regs_bitmap_t rollback_bitmap
);

	// Stage 1 keeps the full op; the ALU works from it
	logic s1_v;
	issue_op_t s1_op;

	// Stages 2 up to the last carry only the result and its target
	logic [EXEC_STAGES:2] st_v;
	logic [REG_W-1:0] st_rd [2:EXEC_STAGES];
	logic [DATA_W-1:0] st_data [2:EXEC_STAGES];

	// ALU output of stage 1
	logic [DATA_W-1:0] alu_res;
	logic [2*DATA_W-1:0] product;

	// ============================================================
	// Stage valid chain
	// ============================================================

	// Flush kills every op in flight on the same edge.
	// Ops without a target occupy no stage at all
	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			s1_v <= 1'b0;
			st_v <= '0;
		end
		else
		begin
			s1_v <= will_issue && issue_op.db.has_rd;
			st_v <= {st_v[EXEC_STAGES-1:2], s1_v};
		end
	end

	// ============================================================
	// Stage 1 ALU
	// ============================================================

	assign product = s1_op.a_val * s1_op.b_val;

	always_comb
	begin
		case (s1_op.db.op)
			OP_LI:
				alu_res = s1_op.db.imm;
			OP_ADD:
				alu_res = s1_op.a_val + s1_op.b_val;
			OP_SUB:
				alu_res = s1_op.a_val - s1_op.b_val;
			OP_MUL:
				alu_res = product[DATA_W-1:0];
			OP_AND:
				alu_res = s1_op.a_val & s1_op.b_val;
			default:
				alu_res = '0;
		endcase
	end

	// ============================================================
	// Payload shift
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (will_issue)
			s1_op <= issue_op;
		st_rd[2] <= s1_op.db.rd;
		st_data[2] <= alu_res;
		for (int i = 3; i <= EXEC_STAGES; i++)
		begin
			st_rd[i] <= st_rd[i-1];
			st_data[i] <= st_data[i-1];
		end
	end

	// Last stage is the writeback port
	assign wb.v = st_v[EXEC_STAGES];
	assign wb.rd = st_rd[EXEC_STAGES];
	assign wb.data = st_data[EXEC_STAGES];

	// Targets still pending in the pipe, handed back to the scoreboard on flush
	always_comb
	begin
		rollback_bitmap = '0;
		if (s1_v && s1_op.db.rf_wr)
			rollback_bitmap[s1_op.db.rd] = 1'b1;
		for (int i = 2; i <= EXEC_STAGES; i++)
			if (st_v[i] && (st_rd[i] != '0))
				rollback_bitmap[st_rd[i]] = 1'b1;
	end

endmodule

// File: source/instr_decoder.sv
module instr_decoder
	import issue_pkg::*;
(
	input instr_t instr,
	output decode_bus_t db
);

	// Pure combinational decode, no state
	always_comb
	begin
		// Register fields and the immediate pass straight through
		db.op = instr.opcode;
		db.rd = instr.rd;
		db.ra = instr.ra;
		db.rb = instr.rb;
		db.imm = instr.imm;
		db.has_ra = 1'b0;
		db.has_rb = 1'b0;
		db.has_rd = 1'b0;

		case (instr.opcode)
			OP_LI:
			begin
				// Load immediate reads no registers
				db.has_rd = 1'b1;
			end
			OP_ADD, OP_SUB, OP_MUL, OP_AND:
			begin
				// Two-source ALU ops
				db.has_ra = 1'b1;
				db.has_rb = 1'b1;
				db.has_rd = 1'b1;
			end
			default:
			begin
				// NOP and the spare encodings do nothing at all
				db.op = OP_NOP;
			end
		endcase

		// A target of r0 is architecturally dropped, so it never reaches the file
		db.rf_wr = db.has_rd && (instr.rd != '0);
	end

endmodule

// File: source/issue_pkg.sv
package issue_pkg;

	// ============================================================
	// Core dimensions
	// ============================================================

	// Architectural register count, r0 reads as zero
	localparam int NUM_REGS = 16;
	localparam int REG_W = 4;
	localparam int DATA_W = 16;

	// Number of execute stages between issue and writeback
	localparam int EXEC_STAGES = 4;

	// One bit per register, used for scoreboard and rollback masks
	typedef logic [NUM_REGS-1:0] regs_bitmap_t;

	// Opcodes 6 and 7 are unused and decode as NOP
	typedef enum logic [2:0] {
		OP_NOP = 3'd0,
		OP_LI  = 3'd1,
		OP_ADD = 3'd2,
		OP_SUB = 3'd3,
		OP_MUL = 3'd4,
		OP_AND = 3'd5
	} opcode_e;

	// ============================================================
	// Bus structures
	// ============================================================

	// Raw instruction word as driven on the req/ack link, 31 bits
	typedef struct packed {
		opcode_e opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [DATA_W-1:0] imm;
	} instr_t;

	// Decoded form with operand and target presence flags
	typedef struct packed {
		opcode_e op;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [DATA_W-1:0] imm;
		logic has_ra;
		logic has_rb;
		logic has_rd;
		logic rf_wr;
	} decode_bus_t;

	// Single writeback port, 21 bits
	typedef struct packed {
		logic v;
		logic [REG_W-1:0] rd;
		logic [DATA_W-1:0] data;
	} wb_bus_t;

	// What the issue stage hands to the execute pipeline
	typedef struct packed {
		decode_bus_t db;
		logic [DATA_W-1:0] a_val;
		logic [DATA_W-1:0] b_val;
	} issue_op_t;

endpackage

// File: source/issue_stage.sv
module issue_stage
	import issue_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input decode_bus_t db,
	input logic can_issue,
	input logic flush,
	output logic will_issue,
	output logic [REG_W-1:0] rd_a_addr,
	output logic [REG_W-1:0] rd_b_addr,
	input logic [DATA_W-1:0] rd_a_data,
	input logic [DATA_W-1:0] rd_b_data,
	output issue_op_t issue_op
);

	// ACKED lasts one cycle after issue, WAIT_LOW holds ack until req drops
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACKED,
		ST_WAIT_LOW
	} ack_state_e;

	ack_state_e state;

	// ============================================================
	// Four-phase handshake
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (will_issue)
						state <= ST_ACKED;
				ST_ACKED:
					state <= req ? ST_WAIT_LOW : ST_IDLE;
				ST_WAIT_LOW:
					if (!req)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Ack is high in both non-idle states
	assign ack = (state != ST_IDLE);

	// A new request is only taken while ack is low, and never during a flush
	assign will_issue = req && (state == ST_IDLE) && can_issue && !flush;

	// ============================================================
	// Operand read and dispatch bundle
	// ============================================================

	// Absent sources read r0, which returns zero
	assign rd_a_addr = db.has_ra ? db.ra : '0;
	assign rd_b_addr = db.has_rb ? db.rb : '0;

	assign issue_op.db = db;
	assign issue_op.a_val = rd_a_data;
	assign issue_op.b_val = rd_b_data;

endmodule

// File: source/issue_top.sv
module issue_top
	import issue_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input instr_t instr,
	input logic flush,
	input logic [REG_W-1:0] host_addr,
	output logic [DATA_W-1:0] host_data,
	output wb_bus_t wb
);

	decode_bus_t db;
	issue_op_t issue_op;
	regs_bitmap_t rollback_bitmap;
	logic can_issue;
	logic will_issue;
	logic [REG_W-1:0] rd_a_addr;
	logic [REG_W-1:0] rd_b_addr;
	logic [DATA_W-1:0] rd_a_data;
	logic [DATA_W-1:0] rd_b_data;

	// ============================================================
	// Front end
	// ============================================================

	instr_decoder u_decoder (
		.instr(instr),
		.db(db)
	);

	// Flush doubles as the rollback strobe
	reg_scoreboard u_scoreboard (
		.clk(clk),
		.rst(rst),
		.db(db),
		.will_issue(will_issue),
		.wb(wb),
		.rollback(flush),
		.rollback_bitmap(rollback_bitmap),
		.can_issue(can_issue)
	);

	issue_stage u_issue (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.db(db),
		.can_issue(can_issue),
		.flush(flush),
		.will_issue(will_issue),
		.rd_a_addr(rd_a_addr),
		.rd_b_addr(rd_b_addr),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.issue_op(issue_op)
	);

	// ============================================================
	// Execute and storage
	// ============================================================

	exec_pipe u_exec (
		.clk(clk),
		.rst(rst),
		.will_issue(will_issue),
		.issue_op(issue_op),
		.flush(flush),
		.wb(wb),
		.rollback_bitmap(rollback_bitmap)
	);

	reg_file u_regs (
		.clk(clk),
		.rst(rst),
		.rd_a_addr(rd_a_addr),
		.rd_b_addr(rd_b_addr),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.host_addr(host_addr),
		.host_data(host_data),
		.wb(wb)
	);

endmodule

// File: source/reg_file.sv
module reg_file
	import issue_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [REG_W-1:0] rd_a_addr,
	input logic [REG_W-1:0] rd_b_addr,
	output logic [DATA_W-1:0] rd_a_data,
	output logic [DATA_W-1:0] rd_b_data,
	input logic [REG_W-1:0] host_addr,
	output logic [DATA_W-1:0] host_data,
	input wb_bus_t wb
);

	logic [DATA_W-1:0] regs [NUM_REGS];

	// ============================================================
	// Write port
	// ============================================================

	// Single write port fed by the pipeline's last stage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb.v && (wb.rd != '0))
			regs[wb.rd] <= wb.data;
	end

	// ============================================================
	// Read ports
	// ============================================================

	// r0 is hardwired to zero on every port
	assign rd_a_data = (rd_a_addr == '0) ? '0 : regs[rd_a_addr];
	assign rd_b_data = (rd_b_addr == '0) ? '0 : regs[rd_b_addr];

	// Host port lets the outside world inspect committed state
	assign host_data = (host_addr == '0) ? '0 : regs[host_addr];

endmodule

// File: source/reg_scoreboard.sv
module reg_scoreboard
	import issue_pkg::*;
(
	input logic clk,
	input logic rst,
	input decode_bus_t db,
	input logic will_issue,
	input wb_bus_t wb,
	input logic rollback,
	input regs_bitmap_t rollback_bitmap,
	output logic can_issue
);

	// A set bit means the register holds its committed value
	regs_bitmap_t valid;
	regs_bitmap_t nxt_valid;

	// Registers the decoded instruction touches
	regs_bitmap_t srcs;

	// Masks that clear and set bits this cycle
	regs_bitmap_t clr_bm;
	regs_bitmap_t set_bm;

	// ============================================================
	// Per-instruction register masks
	// ============================================================

	// Destination is included so that a second writer waits for the first,
	// which keeps writebacks to the same register in order
	always_comb
	begin
		srcs = '0;
		if (db.has_ra)
			srcs[db.ra] = 1'b1;
		if (db.has_rb)
			srcs[db.rb] = 1'b1;
		if (db.has_rd)
			srcs[db.rd] = 1'b1;
	end

	// Issuing marks the target pending
	always_comb
	begin
		clr_bm = '0;
		if (will_issue && db.rf_wr)
			clr_bm[db.rd] = 1'b1;
	end

	// Writeback and rollback both return registers to valid
	always_comb
	begin
		set_bm = rollback ? rollback_bitmap : '0;
		if (wb.v)
			set_bm[wb.rd] = 1'b1;
	end

	// ============================================================
	// Valid bitmap update
	// ============================================================

	always_comb
	begin
		nxt_valid = (valid & ~clr_bm) | set_bm;
		// r0 never waits for anything
		nxt_valid[0] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid <= '1;
		else
			valid <= nxt_valid;
	end

	// Ready when every touched register above r0 is valid
	always_comb
		can_issue = (valid[NUM_REGS-1:1] & srcs[NUM_REGS-1:1]) == srcs[NUM_REGS-1:1];

endmodule
